// ==== hdl/dcache_cfg_pkg.sv ====
// Geometry of the two-way L1 data cache and the split of a CPU address.
// An address splits into tag, index, word offset and an ignored byte offset.
`default_nettype none

package dcache_cfg_pkg;

    localparam int unsigned addr_w          = 32;  // cpu and l2 address width
    localparam int unsigned tag_w           = 20;
    localparam int unsigned index_w         = 8;
    localparam int unsigned sets            = 256; // 2**index_w
    localparam int unsigned offset_w        = 2;   // word within a block

    localparam int unsigned word_w          = 32;
    localparam int unsigned block_w         = 128;
    localparam int unsigned words_per_block = 4;   // block_w / word_w

endpackage

`default_nettype wire

// ==== hdl/dcache_ctrl_pkg.sv ====
// Controller state and way encodings shared by the controller and both arrays.
`default_nettype none

package dcache_ctrl_pkg;

    typedef enum logic [2:0] {
        idle         = 3'd0,
        access       = 3'd1,  // tag compare and hit or miss decision
        write_l1     = 3'd2,  // array write for a write hit or a fill
        wait_l2_busy = 3'd3,
        l2_access    = 3'd4,  // block fetch from l2
        load_block   = 3'd5   // dirty victim write-back
    } ctrl_state_e;

    typedef enum logic {
        way0 = 1'b0,
        way1 = 1'b1
    } way_e;

endpackage

`default_nettype wire

// ==== hdl/dcache_tag_array.sv ====
// Tag, valid and dirty storage for both ways, plus the per-set LRU bit.
// Reads are combinational and writes land on the clock edge.
`timescale 1ns/1ns
`default_nettype none

module dcache_tag_array (
    input  logic                                clk_tmp,
    input  logic                                rst_n,
    input  logic [dcache_cfg_pkg::index_w-1:0]  index,
    input  dcache_ctrl_pkg::way_e               way,
    input  logic [dcache_cfg_pkg::tag_w-1:0]    tag_in,
    input  logic                                tag_we,
    input  logic                                dirty_we,
    input  logic                                dirty_wd,
    input  logic                                touch,
    input  dcache_ctrl_pkg::way_e               hit_way,
    output logic [dcache_cfg_pkg::tag_w-1:0]    tag0,
    output logic [dcache_cfg_pkg::tag_w-1:0]    tag1,
    output logic                                valid0,
    output logic                                valid1,
    output logic                                dirty0,
    output logic                                dirty1,
    output logic                                lru
);

    logic [dcache_cfg_pkg::tag_w-1:0]   tag_mem [2][dcache_cfg_pkg::sets];
    logic [dcache_cfg_pkg::sets-1:0]    dirty_q [2];
    logic [dcache_cfg_pkg::sets-1:0]    valid_q [2];
    logic [dcache_cfg_pkg::sets-1:0]    lru_q;  // names the least recently used way

    always_ff @(posedge clk_tmp) begin
        if (tag_we) begin
            tag_mem[way][index] <= tag_in;
        end
        if (dirty_we) begin
            dirty_q[way][index] <= dirty_wd;
        end
    end

    always_ff @(posedge clk_tmp or negedge rst_n) begin
        if (!rst_n) begin
            valid_q[0] <= '0;
            valid_q[1] <= '0;
            lru_q      <= '0;
        end else begin
            if (tag_we) begin
                valid_q[way][index] <= 1'b1;
            end
            if (touch) begin
                lru_q[index] <= ~hit_way;  // the other way goes stale
            end
        end
    end

    assign tag0   = tag_mem[0][index];
    assign tag1   = tag_mem[1][index];
    assign valid0 = valid_q[0][index];
    assign valid1 = valid_q[1][index];
    assign dirty0 = dirty_q[0][index];
    assign dirty1 = dirty_q[1][index];
    assign lru    = lru_q[index];

endmodule

`default_nettype wire

// ==== hdl/dcache_data_array.sv ====
// Block storage for both ways; both blocks of the indexed set read out at once.
`timescale 1ns/1ns
`default_nettype none

module dcache_data_array (
    input  logic                                clk_tmp,
    input  logic [dcache_cfg_pkg::index_w-1:0]  index,
    input  dcache_ctrl_pkg::way_e               way,
    input  logic                                data_we,
    input  logic [dcache_cfg_pkg::block_w-1:0]  block_wd,
    output logic [dcache_cfg_pkg::block_w-1:0]  blk0,
    output logic [dcache_cfg_pkg::block_w-1:0]  blk1
);

    logic [dcache_cfg_pkg::block_w-1:0] blk_mem [2][dcache_cfg_pkg::sets];

    // single write port with way picking the bank
    always_ff @(posedge clk_tmp) begin
        if (data_we) begin
            blk_mem[way][index] <= block_wd;
        end
    end

    assign blk0 = blk_mem[0][index];
    assign blk1 = blk_mem[1][index];

endmodule

`default_nettype wire

// ==== hdl/dcache_ctrl.sv ====
// Cache controller for hit detection, victim choice and the miss sequence
// of write-back, fill from L2 and replay of the CPU access.
`timescale 1ns/1ns
`default_nettype none

module dcache_ctrl (
    input  logic                                clk_tmp,
    input  logic                                rst_n,
    input  logic                                access,
    input  logic                                mem_write,
    input  logic [dcache_cfg_pkg::addr_w-1:0]   addr,
    input  logic [dcache_cfg_pkg::word_w-1:0]   wdata,
    output logic [dcache_cfg_pkg::word_w-1:0]   rdata,
    output logic                                done,
    output logic                                miss_stall,
    input  logic [dcache_cfg_pkg::tag_w-1:0]    tag0,
    input  logic [dcache_cfg_pkg::tag_w-1:0]    tag1,
    input  logic                                valid0,
    input  logic                                valid1,
    input  logic                                dirty0,
    input  logic                                dirty1,
    input  logic                                lru,
    input  logic [dcache_cfg_pkg::block_w-1:0]  blk0,
    input  logic [dcache_cfg_pkg::block_w-1:0]  blk1,
    output logic [dcache_cfg_pkg::index_w-1:0]  index,
    output dcache_ctrl_pkg::way_e               way,
    output logic                                tag_we,
    output logic                                dirty_we,
    output logic                                dirty_wd,
    output logic                                touch,
    output dcache_ctrl_pkg::way_e               hit_way,
    output logic                                data_we,
    output logic [dcache_cfg_pkg::block_w-1:0]  block_wd,
    output logic                                l2_req,
    output logic [dcache_cfg_pkg::addr_w-1:0]   l2_addr,
    output logic                                l2_write,
    output logic [dcache_cfg_pkg::block_w-1:0]  l2_wdata,
    input  logic [dcache_cfg_pkg::block_w-1:0]  l2_rdata,
    input  logic                                l2_busy,
    input  logic                                l2_rdy,
    input  logic                                l2_complete
);

    dcache_ctrl_pkg::ctrl_state_e               state;
    dcache_ctrl_pkg::way_e                      victim;
    logic [dcache_cfg_pkg::tag_w-1:0]           addr_tag;
    logic [dcache_cfg_pkg::offset_w-1:0]        offset;
    logic                                       hit0;
    logic                                       hit1;
    logic                                       hit;
    logic [dcache_cfg_pkg::block_w-1:0]         hit_blk;
    logic [dcache_cfg_pkg::block_w-1:0]         merged;
    logic                                       victim_valid;
    logic                                       victim_dirty;
    logic [dcache_cfg_pkg::tag_w-1:0]           victim_tag;
    logic [dcache_cfg_pkg::block_w-1:0]         victim_blk;
    logic                                       wb_needed;
    logic                                       wb_done;   // victim already written back
    logic                                       filling;   // write_l1 holds a fill
    logic                                       issue;
    logic                                       rd_hit;
    logic                                       wr_hit;
    logic                                       fill_rdy;

    assign addr_tag = addr[dcache_cfg_pkg::addr_w-1 -: dcache_cfg_pkg::tag_w];
    assign index    = addr[dcache_cfg_pkg::addr_w-dcache_cfg_pkg::tag_w-1 -:
                           dcache_cfg_pkg::index_w];
    assign offset   = addr[dcache_cfg_pkg::addr_w-dcache_cfg_pkg::tag_w-
                           dcache_cfg_pkg::index_w-1 -: dcache_cfg_pkg::offset_w];

    assign hit0    = valid0 && (tag0 == addr_tag);
    assign hit1    = valid1 && (tag1 == addr_tag);
    assign hit     = hit0 || hit1;
    assign hit_way = hit0 ? dcache_ctrl_pkg::way0 : dcache_ctrl_pkg::way1;
    assign hit_blk = (hit_way == dcache_ctrl_pkg::way1) ? blk1 : blk0;

    // an invalid way first, else the way lru names
    always_comb begin
        if (!valid0) begin
            victim = dcache_ctrl_pkg::way0;
        end else if (!valid1) begin
            victim = dcache_ctrl_pkg::way1;
        end else begin
            victim = dcache_ctrl_pkg::way_e'(lru);
        end
    end

    assign victim_valid = (victim == dcache_ctrl_pkg::way1) ? valid1 : valid0;
    assign victim_dirty = (victim == dcache_ctrl_pkg::way1) ? dirty1 : dirty0;
    assign victim_tag   = (victim == dcache_ctrl_pkg::way1) ? tag1 : tag0;
    assign victim_blk   = (victim == dcache_ctrl_pkg::way1) ? blk1 : blk0;
    assign wb_needed    = victim_valid && victim_dirty && !wb_done;

    // write data merged into the hit block
    always_comb begin
        merged = hit_blk;
        for (int i = 0; i < dcache_cfg_pkg::words_per_block; i++) begin
            if (offset == i) begin
                merged[i*dcache_cfg_pkg::word_w +: dcache_cfg_pkg::word_w] = wdata;
            end
        end
    end

    assign rd_hit   = (state == dcache_ctrl_pkg::access) && hit && !mem_write;
    assign wr_hit   = (state == dcache_ctrl_pkg::access) && hit && mem_write;
    assign fill_rdy = (state == dcache_ctrl_pkg::l2_access) && l2_rdy;
    assign issue    = !l2_busy && (((state == dcache_ctrl_pkg::access) && !hit) ||
                                   (state == dcache_ctrl_pkg::wait_l2_busy));

    assign touch    = (state == dcache_ctrl_pkg::access) && hit;
    assign data_we  = (state == dcache_ctrl_pkg::write_l1);
    assign dirty_we = (state == dcache_ctrl_pkg::write_l1);
    assign tag_we   = (state == dcache_ctrl_pkg::write_l1) && filling;
    assign dirty_wd = !filling;  // a fill leaves the block clean

    always_ff @(posedge clk_tmp or negedge rst_n) begin
        if (!rst_n) begin
            state      <= dcache_ctrl_pkg::idle;
            done       <= 1'b0;
            miss_stall <= 1'b0;
            way        <= dcache_ctrl_pkg::way0;
            filling    <= 1'b0;
            wb_done    <= 1'b0;
            l2_req     <= 1'b0;
            l2_write   <= 1'b0;
        end else begin
            done <= 1'b0;
            if (issue) begin
                l2_req   <= 1'b1;
                l2_write <= wb_needed;  // write-back goes before the fill
            end
            case (state)
                dcache_ctrl_pkg::idle: begin
                    if (access && !done) begin  // request still held in the done cycle
                        state <= dcache_ctrl_pkg::access;
                    end
                end
                dcache_ctrl_pkg::access: begin
                    if (hit && mem_write) begin
                        state <= dcache_ctrl_pkg::write_l1;
                        way   <= hit_way;
                    end else if (hit) begin
                        done       <= 1'b1;
                        miss_stall <= 1'b0;
                        state      <= dcache_ctrl_pkg::idle;
                    end else begin
                        miss_stall <= 1'b1;
                        if (l2_busy) begin
                            state <= dcache_ctrl_pkg::wait_l2_busy;
                        end else if (wb_needed) begin
                            state <= dcache_ctrl_pkg::load_block;
                        end else begin
                            state <= dcache_ctrl_pkg::l2_access;
                        end
                    end
                end
                dcache_ctrl_pkg::wait_l2_busy: begin
                    if (!l2_busy) begin
                        state <= wb_needed ? dcache_ctrl_pkg::load_block
                                           : dcache_ctrl_pkg::l2_access;
                    end
                end
                dcache_ctrl_pkg::load_block: begin
                    if (l2_complete) begin
                        l2_req   <= 1'b0;
                        l2_write <= 1'b0;
                        wb_done  <= 1'b1;
                        state    <= dcache_ctrl_pkg::wait_l2_busy;  // fill waits for l2
                    end
                end
                dcache_ctrl_pkg::l2_access: begin
                    if (l2_rdy) begin
                        l2_req  <= 1'b0;
                        way     <= victim;
                        filling <= 1'b1;
                        wb_done <= 1'b0;
                        state   <= dcache_ctrl_pkg::write_l1;
                    end
                end
                dcache_ctrl_pkg::write_l1: begin
                    if (filling) begin
                        filling <= 1'b0;
                        state   <= dcache_ctrl_pkg::access;  // replay now hits
                    end else begin
                        done       <= 1'b1;
                        miss_stall <= 1'b0;
                        state      <= dcache_ctrl_pkg::idle;
                    end
                end
                default: state <= dcache_ctrl_pkg::idle;
            endcase
        end
    end

    // payload registers
    always_ff @(posedge clk_tmp) begin
        if (rd_hit) begin
            rdata <= hit_blk[offset*dcache_cfg_pkg::word_w +: dcache_cfg_pkg::word_w];
        end
        if (wr_hit) begin
            block_wd <= merged;
        end else if (fill_rdy) begin
            block_wd <= l2_rdata;
        end
        if (issue) begin
            l2_addr  <= wb_needed ? {victim_tag, index, {(dcache_cfg_pkg::addr_w-
                                     dcache_cfg_pkg::tag_w-dcache_cfg_pkg::index_w){1'b0}}}
                                  : {addr_tag, index, {(dcache_cfg_pkg::addr_w-
                                     dcache_cfg_pkg::tag_w-dcache_cfg_pkg::index_w){1'b0}}};
            l2_wdata <= victim_blk;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/dcache_top.sv ====
// L1 data cache top with the controller plus tag and data arrays.
// CPU request/done port on one side, L2 request port on the other.
`timescale 1ns/1ns
`default_nettype none

module dcache_top (
    input  logic                                clk_tmp,
    input  logic                                rst_n,
    input  logic                                access,
    input  logic                                mem_write,
    input  logic [dcache_cfg_pkg::addr_w-1:0]   addr,
    input  logic [dcache_cfg_pkg::word_w-1:0]   wdata,
    output logic [dcache_cfg_pkg::word_w-1:0]   rdata,
    output logic                                done,
    output logic                                miss_stall,
    output logic                                l2_req,
    output logic [dcache_cfg_pkg::addr_w-1:0]   l2_addr,
    output logic                                l2_write,
    output logic [dcache_cfg_pkg::block_w-1:0]  l2_wdata,
    input  logic [dcache_cfg_pkg::block_w-1:0]  l2_rdata,
    input  logic                                l2_busy,
    input  logic                                l2_rdy,
    input  logic                                l2_complete
);

    logic [dcache_cfg_pkg::tag_w-1:0]   tag0;
    logic [dcache_cfg_pkg::tag_w-1:0]   tag1;
    logic                               valid0;
    logic                               valid1;
    logic                               dirty0;
    logic                               dirty1;
    logic                               lru;
    logic [dcache_cfg_pkg::block_w-1:0] blk0;
    logic [dcache_cfg_pkg::block_w-1:0] blk1;
    logic [dcache_cfg_pkg::index_w-1:0] index;
    dcache_ctrl_pkg::way_e              way;
    dcache_ctrl_pkg::way_e              hit_way;
    logic                               tag_we;
    logic                               dirty_we;
    logic                               dirty_wd;
    logic                               touch;
    logic                               data_we;
    logic [dcache_cfg_pkg::block_w-1:0] block_wd;

    dcache_ctrl i_ctrl (
        .clk_tmp, .rst_n, .access, .mem_write, .addr, .wdata,
        .rdata, .done, .miss_stall,
        .tag0, .tag1, .valid0, .valid1, .dirty0, .dirty1, .lru, .blk0, .blk1,
        .index, .way, .tag_we, .dirty_we, .dirty_wd, .touch, .hit_way,
        .data_we, .block_wd,
        .l2_req, .l2_addr, .l2_write, .l2_wdata,
        .l2_rdata, .l2_busy, .l2_rdy, .l2_complete
    );

    // a fill always writes the tag of the held cpu address
    dcache_tag_array i_tag_array (
        .clk_tmp, .rst_n, .index, .way,
        .tag_in   (addr[dcache_cfg_pkg::addr_w-1 -: dcache_cfg_pkg::tag_w]),
        .tag_we, .dirty_we, .dirty_wd, .touch, .hit_way,
        .tag0, .tag1, .valid0, .valid1, .dirty0, .dirty1, .lru
    );

    dcache_data_array i_data_array (
        .clk_tmp, .index, .way, .data_we, .block_wd, .blk0, .blk1
    );

endmodule

`default_nettype wire

// ==== sim/dcache_asserts.sv ====
// Protocol checks for the cache controller bound into every dcache_ctrl instance.
`timescale 1ns/1ns
`default_nettype none

module dcache_asserts (
    input logic                                clk_tmp,
    input logic                                rst_n,
    input logic                                done,
    input logic                                l2_req,
    input logic [dcache_cfg_pkg::addr_w-1:0]   l2_addr,
    input logic                                l2_write,
    input logic [dcache_cfg_pkg::block_w-1:0]  l2_wdata,
    input logic                                l2_rdy,
    input logic                                l2_complete,
    input logic                                tag_we,
    input logic                                dirty_we,
    input logic                                data_we
);

    int unsigned fail_cnt = 0;

    // request fields held until the L2 answers
    assert property (@(posedge clk_tmp) disable iff (!rst_n)
        l2_req && !l2_rdy && !l2_complete |=>
            l2_req && $stable(l2_addr) && $stable(l2_write) && $stable(l2_wdata))
    else begin
        fail_cnt++;
        $error("l2 request changed before l2_rdy or l2_complete");
    end

    assert property (@(posedge clk_tmp) disable iff (!rst_n) done |=> !done)
    else begin
        fail_cnt++;
        $error("done pulse wider than one cycle");
    end

    assert property (@(posedge clk_tmp) !rst_n |-> !(tag_we || dirty_we || data_we))
    else begin
        fail_cnt++;
        $error("array write strobe active in reset");
    end

endmodule

bind dcache_ctrl dcache_asserts i_asserts (.*);

`default_nettype wire

// ==== sim/tb_dcache.sv ====
// Testbench for the L1 data cache with an L2 model, a reference memory and random tests.
// Compile with files.f; the run ends with one closing count line and a verdict.
`timescale 1ns/1ns
`default_nettype none

module tb_dcache;

    localparam int n_ops     = 216;                // 16 directed + 200 random accesses
    localparam int cycle_lim = 40 * n_ops + 200;

    logic                                clk_tmp;
    logic                                rst_n;
    logic                                access;
    logic                                mem_write;
    logic [dcache_cfg_pkg::addr_w-1:0]   addr;
    logic [dcache_cfg_pkg::word_w-1:0]   wdata;
    logic [dcache_cfg_pkg::word_w-1:0]   rdata;
    logic                                done;
    logic                                miss_stall;
    logic                                l2_req;
    logic [dcache_cfg_pkg::addr_w-1:0]   l2_addr;
    logic                                l2_write;
    logic [dcache_cfg_pkg::block_w-1:0]  l2_wdata;
    logic [dcache_cfg_pkg::block_w-1:0]  l2_rdata;
    logic                                l2_busy;
    logic                                l2_rdy;
    logic                                l2_complete;

    logic [dcache_cfg_pkg::block_w-1:0]  l2_mem [int unsigned];   // by block number
    logic [dcache_cfg_pkg::word_w-1:0]   ref_mem [int unsigned];  // by word address
    logic [dcache_cfg_pkg::addr_w-1:0]   wb_addr_q [$];
    integer seed       = 97544;
    int     errors     = 0;
    int     checks     = 0;
    int     cycles     = 0;
    int     n_req      = 0;   // L2 requests taken by the model
    int     l2_wait    = -1;  // cycles left before the L2 answers
    bit     busy_en    = 1'b0;
    bit     stall_seen = 1'b0;
    string  test_name  = "reset";

    dcache_top i_dut (.*);

    always #20 clk_tmp = ~clk_tmp;

    function automatic logic [dcache_cfg_pkg::addr_w-1:0] make_addr(
        input logic [dcache_cfg_pkg::tag_w-1:0] tag, input logic [7:0] idx,
        input logic [1:0] off);
        return {tag, idx, off, 2'b00};
    endfunction

    // untouched memory contents mix every address bit
    function automatic logic [dcache_cfg_pkg::word_w-1:0] pattern_word(
        input logic [dcache_cfg_pkg::addr_w-1:0] a);
        return {a[15:0], a[31:16]} ^ (a * 32'h0001_0003) ^ 32'h5a5a_c3c3;
    endfunction

    // expected word from the last CPU write or the untouched pattern
    function automatic logic [dcache_cfg_pkg::word_w-1:0] ref_word(
        input logic [dcache_cfg_pkg::addr_w-1:0] a);
        logic [dcache_cfg_pkg::addr_w-1:0] wa;
        wa = {a[31:2], 2'b00};
        if (ref_mem.exists(wa)) begin
            return ref_mem[wa];
        end
        return pattern_word(wa);
    endfunction

    function automatic logic [dcache_cfg_pkg::block_w-1:0] ref_block(
        input logic [dcache_cfg_pkg::addr_w-1:0] a);
        logic [dcache_cfg_pkg::block_w-1:0] b;
        for (int w = 0; w < dcache_cfg_pkg::words_per_block; w++) begin
            b[w*dcache_cfg_pkg::word_w +: dcache_cfg_pkg::word_w] =
                ref_word({a[31:4], 2'(w), 2'b00});
        end
        return b;
    endfunction

    task automatic compare_word(input string what,
                                input logic [dcache_cfg_pkg::word_w-1:0] exp,
                                input logic [dcache_cfg_pkg::word_w-1:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[ERROR] %s %s: expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic compare_block(input string what,
                                 input logic [dcache_cfg_pkg::block_w-1:0] exp,
                                 input logic [dcache_cfg_pkg::block_w-1:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[ERROR] %s %s: expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic compare_addr(input string what,
                                input logic [dcache_cfg_pkg::addr_w-1:0] exp,
                                input logic [dcache_cfg_pkg::addr_w-1:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[ERROR] %s %s: expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic check_count(input string what, input int exp, input int act);
        checks++;
        if (act != exp) begin
            errors++;
            $display("[ERROR] %s %s: expected %0d, actual %0d", test_name, what, exp, act);
        end
    endtask

    // one CPU access with lat counting cycles from access sampled to done
    task automatic cpu_op(input bit wr, input logic [dcache_cfg_pkg::addr_w-1:0] a,
                          input logic [dcache_cfg_pkg::word_w-1:0] d, output int lat);
        @(posedge clk_tmp);
        #2;
        access     = 1'b1;
        mem_write  = wr;
        addr       = a;
        wdata      = d;
        lat        = 0;
        stall_seen = 1'b0;
        @(posedge clk_tmp);
        do begin
            @(negedge clk_tmp);
            lat++;
            if (miss_stall) begin
                stall_seen = 1'b1;
            end
        end while (!done);
        @(posedge clk_tmp);
        #2;
        access = 1'b0;
    endtask

    always @(posedge clk_tmp) begin
        cycles++;
        if (cycles >= cycle_lim) begin
            $display("Timeout: no end of run after %0d cycles in %s", cycles, test_name);
            $display("Simulation failed");
            $finish;
        end
    end

    // L2 model answering 0 to 5 cycles after a request is seen
    always @(posedge clk_tmp) begin
        int unsigned bn;
        #2;
        l2_rdy      = 1'b0;
        l2_complete = 1'b0;
        l2_busy     = busy_en && (($random(seed) & 3) == 0);
        bn          = l2_addr >> 4;
        if (rst_n && l2_req) begin
            if (l2_wait < 0) begin
                n_req++;
                l2_wait = {$random(seed)} % 6;
            end
            if (l2_wait > 0) begin
                l2_wait--;
            end else if (l2_write) begin
                l2_wait = -1;
                wb_addr_q.push_back(l2_addr);
                compare_block("write-back data", ref_block(l2_addr), l2_wdata);
                l2_mem[bn]  = l2_wdata;
                l2_complete = 1'b1;
            end else begin
                l2_wait = -1;
                for (int w = 0; w < dcache_cfg_pkg::words_per_block; w++) begin
                    l2_rdata[w*dcache_cfg_pkg::word_w +: dcache_cfg_pkg::word_w] =
                        pattern_word({l2_addr[31:4], 2'(w), 2'b00});
                end
                if (l2_mem.exists(bn)) begin
                    l2_rdata = l2_mem[bn];  // block written back earlier
                end
                l2_rdy = 1'b1;
            end
        end
    end

    // reads checked against the reference and writes recorded in it
    always @(negedge clk_tmp) begin
        if (rst_n && done) begin
            if (mem_write) begin
                ref_mem[{addr[31:2], 2'b00}] = wdata;
            end else begin
                compare_word("rdata", ref_word(addr), rdata);
            end
        end
    end

    initial begin
        int lat;
        int n0;
        int w0;
        int afails;
        logic [dcache_cfg_pkg::addr_w-1:0] a;
        clk_tmp     = 1'b0;
        rst_n       = 1'b0;
        access      = 1'b0;
        mem_write   = 1'b0;
        addr        = '0;
        wdata       = '0;
        l2_rdata    = '0;
        l2_busy     = 1'b0;
        l2_rdy      = 1'b0;
        l2_complete = 1'b0;
        repeat (4) @(posedge clk_tmp);
        #2;
        rst_n = 1'b1;
        @(negedge clk_tmp);
        check_count("done, miss_stall, l2_req and l2_write low", 1,
                    (done === 1'b0 && miss_stall === 1'b0 &&
                     l2_req === 1'b0 && l2_write === 1'b0));

        test_name = "cold miss";
        n0 = n_req;
        a  = make_addr(20'h00abc, 8'h05, 2'd2);
        cpu_op(1'b0, a, '0, lat);
        check_count("L2 requests", 1, n_req - n0);
        check_count("miss_stall during miss", 1, stall_seen);

        test_name = "read hit";
        n0 = n_req;
        cpu_op(1'b0, a, '0, lat);
        check_count("read hit latency", 2, lat);
        check_count("L2 requests", 0, n_req - n0);
        check_count("miss_stall during hit", 0, stall_seen);

        test_name = "write hit";
        cpu_op(1'b1, make_addr(20'h00abc, 8'h05, 2'd1), 32'hcafe_0001, lat);
        check_count("write hit latency", 3, lat);
        for (int w = 0; w < 4; w++) begin
            cpu_op(1'b0, make_addr(20'h00abc, 8'h05, 2'(w)), '0, lat);
        end

        test_name = "clean replacement";
        cpu_op(1'b0, make_addr(20'h00100, 8'h10, 2'd0), '0, lat);
        cpu_op(1'b0, make_addr(20'h00200, 8'h10, 2'd1), '0, lat);
        cpu_op(1'b0, make_addr(20'h00100, 8'h10, 2'd2), '0, lat);
        n0 = n_req;
        w0 = wb_addr_q.size();
        cpu_op(1'b0, make_addr(20'h00300, 8'h10, 2'd3), '0, lat);
        check_count("L2 requests for C", 1, n_req - n0);
        check_count("write-backs", 0, wb_addr_q.size() - w0);
        n0 = n_req;
        cpu_op(1'b0, make_addr(20'h00100, 8'h10, 2'd0), '0, lat);
        check_count("L2 requests for A", 0, n_req - n0);

        test_name = "dirty write-back";
        cpu_op(1'b1, make_addr(20'h00111, 8'h20, 2'd3), 32'h1234_5678, lat);
        cpu_op(1'b0, make_addr(20'h00222, 8'h20, 2'd0), '0, lat);
        w0 = wb_addr_q.size();
        cpu_op(1'b0, make_addr(20'h00333, 8'h20, 2'd0), '0, lat);
        check_count("write-backs", 1, wb_addr_q.size() - w0);
        if (wb_addr_q.size() > w0) begin
            compare_addr("write-back address", make_addr(20'h00111, 8'h20, 2'd0), wb_addr_q[w0]);
        end
        cpu_op(1'b0, make_addr(20'h00111, 8'h20, 2'd3), '0, lat);

        test_name = "random mix";
        busy_en = 1'b1;
        for (int i = 0; i < n_ops - 16; i++) begin
            a = make_addr(20'(20'h00400 + ({$random(seed)} % 6)),
                          8'(8'h40 + ({$random(seed)} % 4)), 2'($random(seed)));
            cpu_op(1'($random(seed)), a, $random(seed), lat);
        end
        busy_en = 1'b0;
        repeat (2) @(posedge clk_tmp);

        afails = i_dut.i_ctrl.i_asserts.fail_cnt;
        $display("checks: %0d, errors: %0d, assertion failures: %0d", checks, errors, afails);
        if (errors == 0 && afails == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
hdl/dcache_cfg_pkg.sv
hdl/dcache_ctrl_pkg.sv
hdl/dcache_tag_array.sv
hdl/dcache_data_array.sv
hdl/dcache_ctrl.sv
hdl/dcache_top.sv
sim/dcache_asserts.sv
sim/tb_dcache.sv

// ==== Bender.yml ====
package:
  name: dcache

sources:
  - hdl/dcache_cfg_pkg.sv
  - hdl/dcache_ctrl_pkg.sv
  - hdl/dcache_tag_array.sv
  - hdl/dcache_data_array.sv
  - hdl/dcache_ctrl.sv
  - hdl/dcache_top.sv
  - target: simulation
    files:
      - sim/dcache_asserts.sv
      - sim/tb_dcache.sv
